// File: Bender.yml
package:
  name: div_unit

sources:
  - hdl/div_pkg.sv
  - hdl/div_ctrl.sv
  - hdl/div_operand_prep.sv
  - hdl/div_stage.sv
  - hdl/div_result_fix.sv
  - hdl/div_unit.sv
  - target: simulation
    files:
      - sim/div_checker.sv
      - sim/tb_div_unit.sv

// File: div_unit.f
hdl/div_pkg.sv
hdl/div_ctrl.sv
hdl/div_operand_prep.sv
hdl/div_stage.sv
hdl/div_result_fix.sv
hdl/div_unit.sv
sim/div_checker.sv
sim/tb_div_unit.sv

// File: hdl/div_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module div_ctrl import div_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            in_valid,
    input  wire div_op_e         op,
    input  wire logic            a_sign,
    input  wire logic            b_sign,
    input  wire logic            b_zero,
    input  wire logic            a_min,
    input  wire logic [XLEN-1:0] a,
    output logic                 signed_op,
    output logic                 tail_valid,
    output div_tag_t             tail_tag
);

    logic [XLEN-1:0] valid_q;
    div_tag_t        tag_in;
    div_tag_t        tag_q [XLEN];

    assign signed_op = (op == OP_DIV) || (op == OP_REM);

    always_comb begin
        tag_in.op       = op;
        tag_in.neg_q    = signed_op & (a_sign ^ b_sign);
        tag_in.neg_r    = signed_op & a_sign;    // remainder follows dividend sign
        tag_in.div_zero = b_zero;
        // confirmed against divisor magnitude of 1 at the output
        tag_in.overflow = signed_op & a_min & b_sign;
        tag_in.dividend = a;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[XLEN-2:0], in_valid};
        end
    end

    // tag shift line, same depth as the stage array
    always_ff @(posedge clk) begin
        tag_q[0] <= tag_in;
        for (int i = 1; i < XLEN; i++) begin
            tag_q[i] <= tag_q[i-1];
        end
    end

    assign tail_valid = valid_q[XLEN-1];
    assign tail_tag   = tag_q[XLEN-1];

    a_op_known: assert property (@(posedge clk) disable iff (!rstn)
        in_valid |-> !$isunknown(op))
        else $error("div_ctrl: unknown opcode on a valid request");

endmodule

`default_nettype wire

// File: hdl/div_operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

module div_operand_prep import div_pkg::*; (
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    input  wire logic            signed_op,
    output stage_t               first,
    output logic                 a_sign,
    output logic                 b_sign,
    output logic                 b_zero,
    output logic                 a_min
);

    logic [XLEN-1:0] a_mag;
    logic [XLEN-1:0] b_mag;

    assign a_sign = a[XLEN-1];
    assign b_sign = b[XLEN-1];
    assign b_zero = (b == '0);
    assign a_min  = (a == {1'b1, {(XLEN-1){1'b0}}});

    // two's complement magnitude only for signed ops
    assign a_mag = (signed_op && a_sign) ? (~a + 1'b1) : a;
    assign b_mag = (signed_op && b_sign) ? (~b + 1'b1) : b;

    always_comb begin
        first.rem     = '0;
        first.qd      = a_mag;
        first.divisor = b_mag;
    end

endmodule

`default_nettype wire

// File: hdl/div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int XLEN    = 32;
    localparam int DIV_LAT = XLEN + 1;    // stage registers plus output register

    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } div_op_e;

    // sideband that follows a request down the pipeline
    typedef struct packed {
        div_op_e           op;
        logic              neg_q;       // negate quotient
        logic              neg_r;       // negate remainder
        logic              div_zero;
        logic              overflow;    // signed min dividend, negative divisor
        logic [XLEN-1:0]   dividend;    // original operand a
    } div_tag_t;

    // word handed from one division step to the next
    typedef struct packed {
        logic [XLEN-1:0]   rem;         // partial remainder
        logic [XLEN-1:0]   qd;          // dividend bits out, quotient bits in
        logic [XLEN-1:0]   divisor;     // divisor magnitude
    } stage_t;

endpackage

`default_nettype wire

// File: hdl/div_result_fix.sv
`timescale 1ns/1ps
`default_nettype none

module div_result_fix import div_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rstn,
    input  wire logic     tail_valid,
    input  wire div_tag_t tail_tag,
    input  wire stage_t   last,
    output logic          out_valid,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    logic            is_ovf;
    logic            sel_rem;

    // only b == -1 has magnitude 1 and a set sign bit
    assign is_ovf  = tail_tag.overflow && (last.divisor == XLEN'(1));
    assign sel_rem = (tail_tag.op == OP_REM) || (tail_tag.op == OP_REMU);

    always_comb begin
        quo = tail_tag.neg_q ? (~last.qd + 1'b1) : last.qd;
        rem = tail_tag.neg_r ? (~last.rem + 1'b1) : last.rem;
        if (tail_tag.div_zero) begin
            quo = '1;
            rem = tail_tag.dividend;
        end else if (is_ovf) begin
            quo = tail_tag.dividend;
            rem = '0;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= tail_valid;
        end
    end

    always_ff @(posedge clk) begin
        result <= sel_rem ? rem : quo;
    end

    a_result_known: assert property (@(posedge clk) disable iff (!rstn)
        out_valid |-> !$isunknown(result))
        else $error("div_result_fix: unknown result on a valid strobe");

endmodule

`default_nettype wire

// File: hdl/div_stage.sv
`timescale 1ns/1ps
`default_nettype none

module div_stage import div_pkg::*; (
    input  wire logic   clk,
    input  wire stage_t prev,
    output stage_t      next
);

    logic [XLEN:0]   shifted;
    logic            q_bit;
    logic [XLEN-1:0] rem_n;

    // bring down the next dividend bit
    assign shifted = {prev.rem, prev.qd[XLEN-1]};
    assign q_bit   = (shifted >= {1'b0, prev.divisor});

    always_comb begin
        if (q_bit) begin
            rem_n = shifted[XLEN-1:0] - prev.divisor;    // restoring step
        end else begin
            rem_n = shifted[XLEN-1:0];
        end
    end

    always_ff @(posedge clk) begin
        next.rem     <= rem_n;
        next.qd      <= {prev.qd[XLEN-2:0], q_bit};
        next.divisor <= prev.divisor;
    end

    // holds at every stage since stage 0 starts with a zero remainder
    a_rem_below: assert property (@(posedge clk)
        (!$isunknown(next) && next.divisor != '0) |-> (next.rem < next.divisor))
        else $error("div_stage: partial remainder not below divisor");

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module div_unit import div_pkg::*; (
    input  wire logic            clk,
    input  wire logic            rstn,
    input  wire logic            in_valid,
    input  wire div_op_e         op,
    input  wire logic [XLEN-1:0] a,
    input  wire logic [XLEN-1:0] b,
    output logic                 out_valid,
    output logic [XLEN-1:0]      result
);

    logic     signed_op;
    logic     a_sign;
    logic     b_sign;
    logic     b_zero;
    logic     a_min;
    logic     tail_valid;
    div_tag_t tail_tag;
    stage_t   chain [XLEN+1];    // chain[0] from prep, chain[XLEN] to output

    div_ctrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .in_valid   (in_valid),
        .op         (op),
        .a_sign     (a_sign),
        .b_sign     (b_sign),
        .b_zero     (b_zero),
        .a_min      (a_min),
        .a          (a),
        .signed_op  (signed_op),
        .tail_valid (tail_valid),
        .tail_tag   (tail_tag)
    );

    div_operand_prep u_prep (
        .a         (a),
        .b         (b),
        .signed_op (signed_op),
        .first     (chain[0]),
        .a_sign    (a_sign),
        .b_sign    (b_sign),
        .b_zero    (b_zero),
        .a_min     (a_min)
    );

    // one quotient bit per stage, msb first
    for (genvar i = 0; i < XLEN; i++) begin : g_stage
        div_stage u_stage (
            .clk  (clk),
            .prev (chain[i]),
            .next (chain[i+1])
        );
    end

    div_result_fix u_fix (
        .clk        (clk),
        .rstn       (rstn),
        .tail_valid (tail_valid),
        .tail_tag   (tail_tag),
        .last       (chain[XLEN]),
        .out_valid  (out_valid),
        .result     (result)
    );

endmodule

`default_nettype wire

// File: sim/div_checker.sv
`timescale 1ns/1ps
`default_nettype none

module div_checker import div_pkg::*; #(
    parameter int NAME_CHARS = 16
) (
    input wire logic                    clk,
    input wire logic                    rstn,
    input wire logic                    in_valid,
    input wire div_op_e                 op,
    input wire logic [XLEN-1:0]         a,
    input wire logic [XLEN-1:0]         b,
    input wire logic [8*NAME_CHARS-1:0] name,
    input wire logic                    out_valid,
    input wire logic [XLEN-1:0]         result
);

    typedef struct packed {
        logic [8*NAME_CHARS-1:0] name;
        logic [XLEN-1:0]         expected;
        int                      seq;
        int                      cycle;
    } pending_t;

    pending_t req_q [$];
    int       cycle           = 0;
    int       seq             = 0;
    int       outstanding     = 0;
    int       mismatches      = 0;
    int       protocol_errors = 0;

    // RISC-V M rules, including divide by zero and signed overflow
    function automatic logic [XLEN-1:0] expected_result(input div_op_e f_op,
                                                         input logic [XLEN-1:0] f_a,
                                                         input logic [XLEN-1:0] f_b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [XLEN-1:0] sq;
        logic signed [XLEN-1:0] sr;
        logic                   ovf;
        sa  = f_a;
        sb  = f_b;
        ovf = (f_a == {1'b1, {(XLEN-1){1'b0}}}) && (f_b == '1);
        sq  = '0;
        sr  = '0;
        if (f_b != '0 && !ovf) begin
            sq = sa / sb;    // truncates to zero
            sr = sa % sb;
        end
        case (f_op)
            OP_DIVU: return (f_b == '0) ? '1 : f_a / f_b;
            OP_REMU: return (f_b == '0) ? f_a : f_a % f_b;
            OP_DIV:  return (f_b == '0) ? '1 : (ovf ? f_a : sq);
            default: return (f_b == '0) ? f_a : (ovf ? '0 : sr);
        endcase
    endfunction

    // drop the zero bytes in front of a short name
    function automatic string name_text(input logic [8*NAME_CHARS-1:0] v);
        string s;
        s = "";
        for (int i = NAME_CHARS - 1; i >= 0; i--) begin
            if (v[8*i +: 8] != 8'd0) begin
                s = $sformatf("%s%c", s, v[8*i +: 8]);
            end
        end
        return s;
    endfunction

    always @(posedge clk) begin : watch
        pending_t p;
        if (rstn) begin
            if ($isunknown(out_valid)) begin
                protocol_errors++;
                $display("out_valid is unknown at cycle %0d", cycle);
            end else if (out_valid) begin
                if (req_q.size() == 0) begin
                    protocol_errors++;
                    $display("out_valid high at cycle %0d with no request waiting", cycle);
                end else begin
                    p = req_q.pop_front();
                    if (cycle - p.cycle != DIV_LAT) begin
                        protocol_errors++;
                        $display("request %0d (%s) answered after %0d cycles instead of %0d",
                                 p.seq, name_text(p.name), cycle - p.cycle, DIV_LAT);
                    end
                    if (result !== p.expected) begin
                        mismatches++;
                        $display("[FAIL] %s (request %0d): expected %08h, actual %08h",
                                 name_text(p.name), p.seq, p.expected, result);
                    end
                end
            end
            if (in_valid) begin
                p.name     = name;
                p.expected = expected_result(op, a, b);
                p.seq      = seq;
                p.cycle    = cycle;
                req_q.push_back(p);
                seq++;
            end
            outstanding = req_q.size();
            cycle++;
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_div_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_unit import div_pkg::*; ();

    localparam int NAME_CHARS = 16;
    localparam int N_RANDOM   = 40;
    localparam int MARGIN     = 20;
    localparam int GAP_EVERY  = 9;    // one idle cycle after every ninth request

    typedef struct packed {
        div_op_e                 op;
        logic [XLEN-1:0]         a;
        logic [XLEN-1:0]         b;
        logic [8*NAME_CHARS-1:0] name;
    } entry_t;

    logic                    clk;
    logic                    rstn;
    logic                    in_valid;
    div_op_e                 op;
    logic [XLEN-1:0]         a;
    logic [XLEN-1:0]         b;
    logic [8*NAME_CHARS-1:0] name;
    logic                    out_valid;
    logic [XLEN-1:0]         result;

    entry_t      table_q [$];
    logic [31:0] rng_state;
    int          cycles = 0;
    int          limit;
    int          n_gaps;
    int          timeout_errors;

    div_unit DUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    div_checker #(.NAME_CHARS(NAME_CHARS)) u_chk (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .a         (a),
        .b         (b),
        .name      (name),
        .out_valid (out_valid),
        .result    (result)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        if (rstn) begin
            cycles <= cycles + 1;
        end
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic add_entry(input div_op_e e_op, input logic [XLEN-1:0] e_a,
                             input logic [XLEN-1:0] e_b,
                             input logic [8*NAME_CHARS-1:0] e_name);
        entry_t e;
        e.op   = e_op;
        e.a    = e_a;
        e.b    = e_b;
        e.name = e_name;
        table_q.push_back(e);
    endtask

    task automatic build_table();
        logic [31:0] r;
        logic [31:0] ra;
        logic [31:0] rb;
        add_entry(OP_DIVU, 32'd100, 32'd7, "divu_small");
        add_entry(OP_REMU, 32'd100, 32'd7, "remu_small");
        add_entry(OP_DIVU, 32'hffff_ffff, 32'd1, "divu_ones_by_1");
        add_entry(OP_REMU, 32'hffff_ffff, 32'd10, "remu_ones_by_10");
        add_entry(OP_DIVU, 32'hffff_ffff, 32'hffff_ffff, "divu_ones_ones");
        add_entry(OP_DIVU, 32'h8000_0000, 32'd3, "divu_large");
        add_entry(OP_REMU, 32'h1234_5678, 32'd1000, "remu_large");
        add_entry(OP_DIV, 32'd7, 32'd2, "div_pos_pos");
        add_entry(OP_REM, 32'd7, 32'd2, "rem_pos_pos");
        add_entry(OP_DIV, 32'hffff_fff9, 32'd2, "div_neg_pos");
        add_entry(OP_REM, 32'hffff_fff9, 32'd2, "rem_neg_pos");
        add_entry(OP_DIV, 32'd7, 32'hffff_fffe, "div_pos_neg");
        add_entry(OP_REM, 32'd7, 32'hffff_fffe, "rem_pos_neg");
        add_entry(OP_DIV, 32'hffff_fff9, 32'hffff_fffe, "div_neg_neg");
        add_entry(OP_REM, 32'hffff_fff9, 32'hffff_fffe, "rem_neg_neg");
        add_entry(OP_DIV, 32'd5, 32'd0, "div_by_zero");
        add_entry(OP_DIVU, 32'd5, 32'd0, "divu_by_zero");
        add_entry(OP_REM, 32'hffff_fffb, 32'd0, "rem_by_zero");
        add_entry(OP_REMU, 32'd5, 32'd0, "remu_by_zero");
        add_entry(OP_DIV, 32'h8000_0000, 32'hffff_ffff, "div_overflow");
        add_entry(OP_REM, 32'h8000_0000, 32'hffff_ffff, "rem_overflow");
        add_entry(OP_DIV, 32'h8000_0000, 32'd1, "div_min_by_1");
        add_entry(OP_DIVU, 32'h8000_0000, 32'hffff_ffff, "divu_min_ones");
        for (int i = 0; i < N_RANDOM; i++) begin
            r  = next_rand();
            ra = next_rand();
            rb = next_rand();
            if (r[3:2] == 2'b00) begin
                rb = rb >> 20;    // small divisors
            end
            if (r[6:4] == 3'b000) begin
                rb = '0;
            end
            add_entry(div_op_e'(r[1:0]), ra, rb, "random");
        end
    endtask

    initial begin
        entry_t e;
        clk            = 1'b0;
        rstn           = 1'b0;
        in_valid       = 1'b0;
        op             = OP_DIVU;
        a              = '0;
        b              = '0;
        name           = '0;
        timeout_errors = 0;
        rng_state      = 32'd98397;
        build_table();
        n_gaps = 0;
        for (int i = 0; i < table_q.size(); i++) begin
            if (i % GAP_EVERY == GAP_EVERY - 1) begin
                n_gaps++;
            end
        end
        limit = table_q.size() + n_gaps + DIV_LAT + MARGIN;

        repeat (16) @(posedge clk);
        rstn <= 1'b1;

        for (int i = 0; i < table_q.size(); i++) begin
            e = table_q[i];
            @(posedge clk);
            in_valid <= 1'b1;
            op       <= e.op;
            a        <= e.a;
            b        <= e.b;
            name     <= e.name;
            if (i % GAP_EVERY == GAP_EVERY - 1) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;

        @(negedge clk);
        while (u_chk.outstanding != 0 && cycles < limit) begin
            @(negedge clk);
        end
        if (u_chk.outstanding != 0) begin
            timeout_errors++;
            $display("timeout after %0d cycles with %0d requests still outstanding",
                     cycles, u_chk.outstanding);
        end else begin
            repeat (3) @(negedge clk);    // catch stray strobes
        end

        $display("errors: %0d mismatches, %0d protocol, %0d timeout",
                 u_chk.mismatches, u_chk.protocol_errors, timeout_errors);
        if (u_chk.mismatches + u_chk.protocol_errors + timeout_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
